//--- icache_sys_cfg.svh
`ifndef ICACHE_SYS_CFG_SVH
`define ICACHE_SYS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////

// Direct mapped, one block per line
`define ICACHE_LINES       32
`define ICACHE_LINE_BITS   5

// Address bits 15..8 form the cache tag
`define ICACHE_TAG_BITS    8

// Byte offset inside a 64 bit block, address bits 2..0
`define BLOCK_OFFSET_BITS  3

//////////////////////////////////////////////////////////////////////
// Memory model
//////////////////////////////////////////////////////////////////////

// Tags 1..15 are live, tag 0 means no transaction
`define MEM_TAGS           15
`define MEM_TAG_BITS       4

// Cycles from the launch edge to the returned block
`define MEM_LATENCY        8

// Backing store depth, one entry per block number
`define MEM_BLOCKS         8192

// Width of one block, and of one cache line
`define BLOCK_BITS         64

`endif

//--- icache_sys_pkg.sv
`default_nettype none
`include "icache_sys_cfg.svh"

package icache_sys_pkg;

    // Byte address from the fetch unit
    typedef logic [31:0] addr_t;

    // One memory block, also the size of a cache line
    typedef logic [`BLOCK_BITS-1:0] mem_block_t;

    // Memory transaction tag, zero is the sentinel
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // Cache tag and line index fields of the address
    typedef logic [`ICACHE_TAG_BITS-1:0]  icache_tag_t;
    typedef logic [`ICACHE_LINE_BITS-1:0] icache_index_t;

    // Block number, address bits 15..3
    typedef logic [`ICACHE_TAG_BITS+`ICACHE_LINE_BITS-1:0] block_addr_t;

    // Command from the cache to memory
    typedef enum logic [1:0] {
        MEM_NONE = 2'h0,
        MEM_LOAD = 2'h1
    } mem_command_t;

endpackage

`default_nettype wire

//--- icache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module icache_line_ram (
    input  wire logic                          clock,

    // Read port, combinational
    input  wire icache_sys_pkg::icache_index_t raddr,
    output icache_sys_pkg::mem_block_t         rdata,

    // Write port, takes effect at the edge
    input  wire logic                          we,
    input  wire icache_sys_pkg::icache_index_t waddr,
    input  wire icache_sys_pkg::mem_block_t    wdata
);

    // Line storage, valid bits are kept by the cache
    icache_sys_pkg::mem_block_t lines [`ICACHE_LINES];

    //////////////////////////////////////////////////////////////////////
    // Write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (we) begin
            lines[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read
    //////////////////////////////////////////////////////////////////////

    // No bypass, a same cycle write shows up next cycle
    assign rdata = lines[raddr];

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module icache (
    input  wire logic                       clock,
    input  wire logic                       reset,

    // Fetch unit request
    input  wire icache_sys_pkg::addr_t      fetch_addr,

    // Memory replies
    input  wire icache_sys_pkg::mem_tag_t   transaction_tag,
    input  wire icache_sys_pkg::mem_tag_t   data_tag,
    input  wire icache_sys_pkg::mem_block_t mem_data,

    // Memory request
    output icache_sys_pkg::mem_command_t    mem_command,
    output icache_sys_pkg::addr_t           mem_addr,

    // Fetch unit reply
    output icache_sys_pkg::mem_block_t      fetch_data,
    output logic                            fetch_valid,
    output icache_sys_pkg::addr_t           next_invalid_line
);

    // Address fields
    icache_sys_pkg::icache_tag_t   current_tag;
    icache_sys_pkg::icache_index_t current_index;
    icache_sys_pkg::icache_tag_t   last_tag;
    icache_sys_pkg::icache_index_t last_index;

    // Tag and valid arrays
    icache_sys_pkg::icache_tag_t   line_tags [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]      line_valid;

    // Miss tracking
    icache_sys_pkg::mem_tag_t      awaited_tag;
    logic                          miss_outstanding;
    logic                          changed_addr;
    logic                          update_tag;
    logic                          unanswered_miss;
    logic                          fill;

    // Next invalid search
    icache_sys_pkg::icache_index_t invalid_index;
    icache_sys_pkg::icache_tag_t   invalid_tag;
    logic                          found_invalid;

    assign current_tag   = fetch_addr[15:8];
    assign current_index = fetch_addr[7:3];

    icache_line_ram line_ram (
        .clock (clock),
        .raddr (current_index),
        .rdata (fetch_data),
        .we    (fill),
        .waddr (current_index),
        .wdata (mem_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Hit check
    //////////////////////////////////////////////////////////////////////

    assign fetch_valid = line_valid[current_index] &&
                         (line_tags[current_index] == current_tag);

    //////////////////////////////////////////////////////////////////////
    // Miss handling
    //////////////////////////////////////////////////////////////////////

    assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

    // Fill only for the address that issued the load
    assign fill = (awaited_tag == data_tag) && (awaited_tag != '0) && !changed_addr;

    // Tag from memory is zero unless a load was accepted this cycle
    assign update_tag = changed_addr || miss_outstanding || fill;

    // Pending until memory hands out a tag
    assign unanswered_miss = changed_addr ? !fetch_valid
                                          : miss_outstanding && (transaction_tag == '0);

    // Level held load, dropped at once when the address moves
    assign mem_command = (miss_outstanding && !changed_addr) ? icache_sys_pkg::MEM_LOAD
                                                             : icache_sys_pkg::MEM_NONE;
    assign mem_addr    = {fetch_addr[31:3], 3'b000};

    //////////////////////////////////////////////////////////////////////
    // Next invalid line
    //////////////////////////////////////////////////////////////////////

    always_comb begin : search
        icache_sys_pkg::icache_index_t probe;
        found_invalid = 1'b0;
        invalid_index = current_index;
        invalid_tag   = icache_sys_pkg::icache_tag_t'(current_tag + 1'b1);
        // Upward from the current index, wrapping at the top
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            probe = current_index + icache_sys_pkg::icache_index_t'(i);
            if (!found_invalid && !line_valid[probe]) begin
                found_invalid = 1'b1;
                invalid_index = probe;
                // Wrapped lines belong to the next tag
                if (probe < current_index) begin
                    invalid_tag = icache_sys_pkg::icache_tag_t'(current_tag + 1'b1);
                end else begin
                    invalid_tag = current_tag;
                end
            end
        end
    end

    assign next_invalid_line = {{(32 - `ICACHE_TAG_BITS - `ICACHE_LINE_BITS - 3){1'b0}},
                                invalid_tag, invalid_index, 3'b000};

    //////////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // All ones so the first address counts as new
            last_index       <= '1;
            last_tag         <= '1;
            awaited_tag      <= '0;
            miss_outstanding <= 1'b0;
            line_valid       <= '0;
        end else begin
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;
            if (update_tag) begin
                awaited_tag <= transaction_tag;
            end
            if (fill) begin
                line_valid[current_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            line_tags[current_index] <= current_tag;
        end
    end

    // Nothing is requested straight out of reset
    assert property (@(posedge clock) $past(reset) |-> mem_command == icache_sys_pkg::MEM_NONE);

    // A fill answers a real transaction and lands on a line that missed
    assert property (@(posedge clock) disable iff (reset)
        fill |-> (awaited_tag != '0) && !fetch_valid);

endmodule

`default_nettype wire

//--- mem_tag_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module mem_tag_issue (
    input  wire logic                         clock,
    input  wire logic                         reset,

    // Request from the cache
    input  wire icache_sys_pkg::mem_command_t mem_command,
    input  wire icache_sys_pkg::addr_t        mem_addr,

    // Preload of the backing store
    input  wire logic                         load_en,
    input  wire icache_sys_pkg::block_addr_t  load_addr,
    input  wire icache_sys_pkg::mem_block_t   load_data,

    // Slot bank
    input  wire logic [`MEM_TAGS-1:0]         busy,
    output logic [`MEM_TAGS-1:0]              launch,
    output icache_sys_pkg::mem_block_t        launch_data,

    // Tag back to the cache in the same cycle
    output icache_sys_pkg::mem_tag_t          transaction_tag
);

    icache_sys_pkg::mem_block_t  store [`MEM_BLOCKS];
    icache_sys_pkg::block_addr_t read_block;
    logic                        found_free;

    //////////////////////////////////////////////////////////////////////
    // Backing store
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load_en) begin
            store[load_addr] <= load_data;
        end
    end

    // Block number from address bits 15..3
    assign read_block  = mem_addr[`ICACHE_TAG_BITS + `ICACHE_LINE_BITS + `BLOCK_OFFSET_BITS - 1:
                                  `BLOCK_OFFSET_BITS];
    assign launch_data = store[read_block];

    //////////////////////////////////////////////////////////////////////
    // Slot choice
    //////////////////////////////////////////////////////////////////////

    // Lowest free slot wins and slot k carries tag k+1
    always_comb begin
        launch          = '0;
        transaction_tag = '0;
        found_free      = 1'b0;
        if (mem_command == icache_sys_pkg::MEM_LOAD) begin
            for (int k = 0; k < `MEM_TAGS; k++) begin
                if (!found_free && !busy[k]) begin
                    found_free      = 1'b1;
                    launch[k]       = 1'b1;
                    transaction_tag = icache_sys_pkg::mem_tag_t'(k + 1);
                end
            end
        end
    end

    // At most one launch per cycle
    assert property (@(posedge clock) disable iff (reset) $onehot0(launch));

endmodule

`default_nettype wire

//--- mem_tag_slot.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module mem_tag_slot (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       launch,
    input  wire icache_sys_pkg::mem_block_t launch_data,
    output logic                            busy,
    output logic                            done,
    output icache_sys_pkg::mem_block_t      block
);

    // Cycles left before the block is returned
    logic [$clog2(`MEM_LATENCY + 1)-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (launch) begin
            busy  <= 1'b1;
            count <= $bits(count)'(`MEM_LATENCY - 1);
        end else if (done) begin
            // Free again, can be relaunched next cycle
            busy  <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // Payload captured at launch
    always_ff @(posedge clock) begin
        if (launch) begin
            block <= launch_data;
        end
    end

    // One cycle pulse, MEM_LATENCY cycles after the launch edge
    assign done = busy && (count == '0);

    // Issue only picks idle slots
    assert property (@(posedge clock) disable iff (reset) launch |-> !busy);

endmodule

`default_nettype wire

//--- mem_response_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module mem_response_mux (
    // Only for the check below
    input  wire logic                       clock,
    input  wire logic [`MEM_TAGS-1:0]       done,
    input  wire icache_sys_pkg::mem_block_t blocks [`MEM_TAGS],
    output icache_sys_pkg::mem_tag_t        data_tag,
    output icache_sys_pkg::mem_block_t      response_data
);

    // Tag is slot number plus one, zero when idle
    always_comb begin
        data_tag      = '0;
        response_data = '0;
        for (int k = 0; k < `MEM_TAGS; k++) begin
            if (done[k]) begin
                data_tag      = icache_sys_pkg::mem_tag_t'(k + 1);
                response_data = blocks[k];
            end
        end
    end

    // Fixed latency and one issue per cycle keep finishes apart
    assert property (@(posedge clock) $onehot0(done));

endmodule

`default_nettype wire

//--- icache_sys_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module icache_sys_top (
    input  wire logic                        clock,
    input  wire logic                        reset,

    // Fetch side
    input  wire icache_sys_pkg::addr_t       fetch_addr,
    output icache_sys_pkg::mem_block_t       fetch_data,
    output logic                             fetch_valid,
    output icache_sys_pkg::addr_t            next_invalid_line,

    // Backing store preload
    input  wire logic                        load_en,
    input  wire icache_sys_pkg::block_addr_t load_addr,
    input  wire icache_sys_pkg::mem_block_t  load_data
);

    // Cache and issue stage
    icache_sys_pkg::mem_command_t mem_command;
    icache_sys_pkg::addr_t        mem_addr;
    icache_sys_pkg::mem_tag_t     transaction_tag;

    // Issue stage and slot bank
    logic [`MEM_TAGS-1:0]         launch;
    logic [`MEM_TAGS-1:0]         busy;
    icache_sys_pkg::mem_block_t   launch_data;

    // Slot bank and response stage
    logic [`MEM_TAGS-1:0]         done;
    icache_sys_pkg::mem_block_t   blocks [`MEM_TAGS];
    icache_sys_pkg::mem_tag_t     data_tag;
    icache_sys_pkg::mem_block_t   response_data;

    //////////////////////////////////////////////////////////////////////
    // Cache
    //////////////////////////////////////////////////////////////////////

    icache icache0 (
        .clock             (clock),
        .reset             (reset),
        .fetch_addr        (fetch_addr),
        .transaction_tag   (transaction_tag),
        .data_tag          (data_tag),
        .mem_data          (response_data),
        .mem_command       (mem_command),
        .mem_addr          (mem_addr),
        .fetch_data        (fetch_data),
        .fetch_valid       (fetch_valid),
        .next_invalid_line (next_invalid_line)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    mem_tag_issue issue0 (
        .clock           (clock),
        .reset           (reset),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .busy            (busy),
        .launch          (launch),
        .launch_data     (launch_data),
        .transaction_tag (transaction_tag)
    );

    // One slot per live tag
    for (genvar k = 0; k < `MEM_TAGS; k++) begin : slots
        mem_tag_slot slot (
            .clock       (clock),
            .reset       (reset),
            .launch      (launch[k]),
            .launch_data (launch_data),
            .busy        (busy[k]),
            .done        (done[k]),
            .block       (blocks[k])
        );
    end

    mem_response_mux response0 (
        .clock         (clock),
        .done          (done),
        .blocks        (blocks),
        .data_tag      (data_tag),
        .response_data (response_data)
    );

endmodule

`default_nettype wire

//--- icache_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_sys_cfg.svh"

module icache_sys_tb;

    // Test lengths and random stream
    localparam int RANDOM_STEPS = 300;
    localparam int MAX_HOLD     = 20;
    localparam int TOTAL_STEPS  = RANDOM_STEPS + 60;
    localparam int MISS_CYCLES  = `MEM_LATENCY + 4;
    localparam int LIMIT_CYCLES = `MEM_BLOCKS + TOTAL_STEPS * (MISS_CYCLES + MAX_HOLD) + 500;

    int seed = 91298;

    logic                        clock;
    logic                        reset;
    icache_sys_pkg::addr_t       fetch_addr;
    icache_sys_pkg::mem_block_t  fetch_data;
    logic                        fetch_valid;
    icache_sys_pkg::addr_t       next_invalid_line;
    logic                        load_en;
    icache_sys_pkg::block_addr_t load_addr;
    icache_sys_pkg::mem_block_t  load_data;

    // Mirror of the backing store and of the cache lines seen valid
    icache_sys_pkg::mem_block_t  model_mem [`MEM_BLOCKS];
    logic [`ICACHE_LINES-1:0]    model_valid;
    icache_sys_pkg::icache_tag_t model_tag [`ICACHE_LINES];

    int errors;
    int checks;
    int tests_run;
    int errors_before;

    icache_sys_top dut0 (
        .clock             (clock),
        .reset             (reset),
        .fetch_addr        (fetch_addr),
        .fetch_data        (fetch_data),
        .fetch_valid       (fetch_valid),
        .next_invalid_line (next_invalid_line),
        .load_en           (load_en),
        .load_addr         (load_addr),
        .load_data         (load_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    // Block number is address bits 15..3
    function automatic icache_sys_pkg::mem_block_t expected_block(input icache_sys_pkg::addr_t a);
        return model_mem[a[15:3]];
    endfunction

    // First invalid line at or above the index, wrapping, tag bumped past the wrap
    function automatic icache_sys_pkg::addr_t expected_next_invalid(input icache_sys_pkg::addr_t a);
        int index;
        int line;
        logic [7:0] tag;
        logic [7:0] hint_tag;
        int hint_line;
        index     = a[7:3];
        tag       = a[15:8];
        hint_line = index;
        hint_tag  = tag + 8'd1;
        for (int step = `ICACHE_LINES - 1; step >= 0; step--) begin
            // Walk backwards so the nearest invalid line is kept last
            line = (index + step) % `ICACHE_LINES;
            if (!model_valid[line]) begin
                hint_line = line;
                hint_tag  = (line < index) ? tag + 8'd1 : tag;
            end
        end
        return {16'h0000, hint_tag, hint_line[4:0], 3'b000};
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Comparator, samples just after each rising edge
    ///////////////////////////////////////////////////////////////////////

    initial begin : compare
        forever begin
            @(posedge clock);
            #1;
            if (!reset && fetch_valid === 1'b1) begin
                // Held address hit, so its line is filled with its tag
                model_valid[fetch_addr[7:3]] = 1'b1;
                model_tag[fetch_addr[7:3]]   = fetch_addr[15:8];
                checks = checks + 2;
                assert (fetch_data === expected_block(fetch_addr)) else begin
                    $display("FAIL t=%0t: data %h at address %h, expected %h",
                             $time, fetch_data, fetch_addr, expected_block(fetch_addr));
                    errors++;
                end
                assert (next_invalid_line === expected_next_invalid(fetch_addr)) else begin
                    $display("FAIL t=%0t: next invalid %h at address %h, expected %h",
                             $time, next_invalid_line, fetch_addr,
                             expected_next_invalid(fetch_addr));
                    errors++;
                end
            end
        end
    end

    // Ends a hung run
    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clock);
        $display("Timeout, the test hung and did not finish in %0d cycles", LIMIT_CYCLES);
        $display("Test failed");
        $finish;
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ///////////////////////////////////////////////////////////////////////

    function automatic icache_sys_pkg::addr_t make_addr(input logic [7:0] tag,
                                                        input logic [4:0] index,
                                                        input logic [2:0] offset);
        return {16'h0000, tag, index, offset};
    endfunction

    // New address on the falling edge, first cycle hit checked against the model
    task automatic present(input icache_sys_pkg::addr_t a);
        logic moved;
        logic expect_hit;
        @(negedge clock);
        moved      = (a[15:3] != fetch_addr[15:3]);
        expect_hit = model_valid[a[7:3]] && (model_tag[a[7:3]] == a[15:8]);
        fetch_addr = a;
        @(posedge clock);
        #1;
        // Same block keeps a pending fill, so no first cycle check
        if (moved) begin
            checks++;
            assert (fetch_valid === expect_hit) else begin
                $display("FAIL t=%0t: fetch_valid %b at address %h, expected %b",
                         $time, fetch_valid, a, expect_hit);
                errors++;
            end
        end
    endtask

    task automatic hold(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
        end
    endtask

    // Miss must end within the worst miss time
    task automatic wait_valid(input string what);
        int cycles;
        cycles = 0;
        while (fetch_valid !== 1'b1 && cycles < MISS_CYCLES) begin
            hold(1);
            cycles++;
        end
        checks++;
        assert (fetch_valid === 1'b1) else begin
            $display("Miss for %s at address %h was never answered", what, fetch_addr);
            errors++;
        end
    endtask

    task automatic expect_valid(input logic want, input string what);
        checks++;
        assert (fetch_valid === want) else begin
            $display("FAIL t=%0t: %s, fetch_valid %b, expected %b",
                     $time, what, fetch_valid, want);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("%s: finished with %0d new errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Tests
    ///////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        icache_sys_pkg::addr_t a;
        icache_sys_pkg::addr_t b;
        int steps;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        errors_before = 0;
        model_valid   = '0;
        reset         = 1'b1;
        // Equals the all ones last address, so the idle cache fetches nothing
        fetch_addr    = 32'h0000_fff8;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;

        // Random contents for the whole backing store
        for (int blk = 0; blk < `MEM_BLOCKS; blk++) begin
            @(negedge clock);
            load_en   = 1'b1;
            load_addr = blk[12:0];
            load_data = {$random(seed), $random(seed)};
            model_mem[blk] = load_data;
        end
        @(negedge clock);
        load_en = 1'b0;

        // Cold miss
        a = make_addr(8'h12, 5'd3, 3'd5);
        present(a);
        wait_valid("cold miss");
        finish_test("cold miss");

        // Hit after visiting another index
        present(make_addr(8'h40, 5'd9, 3'd0));
        wait_valid("second line");
        present(a);
        expect_valid(1'b1, "refetch of a filled line");
        finish_test("hit after fill");

        // Same index, two tags
        a = make_addr(8'h21, 5'd14, 3'd2);
        b = make_addr(8'h77, 5'd14, 3'd6);
        for (int turn = 0; turn < 3; turn++) begin
            present(a);
            wait_valid("conflict first tag");
            present(b);
            wait_valid("conflict second tag");
        end
        finish_test("conflict");

        // Leave a miss after its load is in flight
        a = make_addr(8'h5a, 5'd20, 3'd0);
        b = make_addr(8'h33, 5'd21, 3'd4);
        present(a);
        hold(3);
        present(b);
        wait_valid("replacement address");
        hold(`MEM_LATENCY + 2);
        present(a);
        expect_valid(1'b0, "abandoned line read valid");
        wait_valid("refill of abandoned line");
        finish_test("abandoned miss");

        // Fill every line starting mid array, wrap case then all valid
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            present(make_addr(8'h60, 5'((16 + i) % `ICACHE_LINES), 3'd1));
            wait_valid("line sweep");
        end
        present(make_addr(8'h60, 5'd7, 3'd0));
        present(make_addr(8'hff, 5'd7, 3'd0));
        wait_valid("all valid");
        finish_test("next invalid line");

        // Random walk over the store
        for (int step = 0; step < RANDOM_STEPS; step++) begin
            a = $random(seed);
            a[31:16] = 16'h0000;
            steps = (($random(seed) & 32'h7fff_ffff) % MAX_HOLD) + 1;
            present(a);
            hold(steps - 1);
        end
        hold(MISS_CYCLES);
        finish_test("random walk");

        $display("Ran %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_sys.f
+incdir+.
icache_sys_pkg.sv
icache_line_ram.sv
icache.sv
mem_tag_issue.sv
mem_tag_slot.sv
mem_response_mux.sv
icache_sys_top.sv
icache_sys_tb.sv
